//--- Bender.yml
package:
  name: bridge

sources:
  - source/bridge_pkg.sv
  - source/port_ctrl.sv
  - source/stream_fifo.sv
  - source/mac_tx_feeder.sv
  - source/rx_payload_cut.sv
  - source/uplink_mux.sv
  - source/bridge_top.sv
  - target: test
    files:
      - testbench/tb_bridge_top.sv

//--- build.f
source/bridge_pkg.sv
source/port_ctrl.sv
source/stream_fifo.sv
source/mac_tx_feeder.sv
source/rx_payload_cut.sv
source/uplink_mux.sv
source/bridge_top.sv
testbench/tb_bridge_top.sv

//--- source/bridge_pkg.sv
// bridge package
// port count, FIFO sizing and the beat types shared by the bridge datapath
`default_nettype none

package bridge_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int NUM_PORTS    = 4;
    localparam int PORT_IDX_W   = 2;
    localparam int RX_HDR_BYTES = 12;   // leading bytes stripped per rx frame
    localparam int FIFO_DEPTH   = 32;   // power of two, pointers wrap

    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CUT_CNT_W  = $clog2(RX_HDR_BYTES + 2);  // counts up to hdr + 1

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef logic [7:0]            byte_t;
    typedef logic [PORT_IDX_W-1:0] port_idx_t;
    typedef logic [NUM_PORTS-1:0]  port_mask_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } tx_beat_t;    // uplink to mac

    typedef struct packed {
        byte_t data;
        logic  sof;
        logic  last;
    } rx_beat_t;    // mac to uplink

endpackage

`default_nettype wire

//--- source/bridge_top.sv
// four-port ethernet to uplink bridge
// port control, uplink mux and one tx/rx datapath per ethernet port
`timescale 1ns/1ps
`default_nettype none

module bridge_top import bridge_pkg::*; (
    input  logic       clk125M,
    input  logic       rst_n_i,
    input  logic       module_en_i,
    input  port_idx_t  port_sel_i,
    input  port_mask_t link_up_i,
    input  logic       channel_up_i,
    input  byte_t      uplink_rx_data_i,
    input  logic       uplink_rx_valid_i,
    input  logic       uplink_rx_last_i,
    output byte_t      uplink_tx_data_o,
    output logic       uplink_tx_valid_o,
    output logic       uplink_tx_sof_o,
    output logic       uplink_tx_last_o,
    input  logic       uplink_tx_ready_i,
    output port_mask_t mac_tx_req_o,
    input  port_mask_t mac_tx_ack_i,
    output byte_t      mac_tx_data_o [NUM_PORTS],
    output port_mask_t mac_tx_valid_o,
    output port_mask_t mac_tx_sof_o,
    output port_mask_t mac_tx_last_o,
    input  byte_t      mac_rx_data_i [NUM_PORTS],
    input  port_mask_t mac_rx_valid_i,
    input  port_mask_t mac_rx_sof_i,
    input  port_mask_t mac_rx_eof_i
);

    port_mask_t port_en;
    port_idx_t  active_port;
    logic       frame_busy;
    tx_beat_t   tx_wr_beat;
    port_mask_t tx_wr_valid;
    rx_beat_t   rx_beats [NUM_PORTS];
    port_mask_t rx_valid;
    port_mask_t rx_ready;

    port_ctrl u_port_ctrl (
        .clk125M       (clk125M),
        .rst_n_i       (rst_n_i),
        .module_en_i   (module_en_i),
        .port_sel_i    (port_sel_i),
        .link_up_i     (link_up_i),
        .channel_up_i  (channel_up_i),
        .frame_busy_i  (frame_busy),
        .port_en_o     (port_en),
        .active_port_o (active_port)
    );

    uplink_mux u_uplink_mux (
        .clk125M           (clk125M),
        .rst_n_i           (rst_n_i),
        .port_en_i         (port_en),
        .active_port_i     (active_port),
        .uplink_rx_data_i  (uplink_rx_data_i),
        .uplink_rx_valid_i (uplink_rx_valid_i),
        .uplink_rx_last_i  (uplink_rx_last_i),
        .tx_wr_beat_o      (tx_wr_beat),
        .tx_wr_valid_o     (tx_wr_valid),
        .rx_beats_i        (rx_beats),
        .rx_valid_i        (rx_valid),
        .rx_ready_o        (rx_ready),
        .uplink_tx_data_o  (uplink_tx_data_o),
        .uplink_tx_valid_o (uplink_tx_valid_o),
        .uplink_tx_sof_o   (uplink_tx_sof_o),
        .uplink_tx_last_o  (uplink_tx_last_o),
        .uplink_tx_ready_i (uplink_tx_ready_i),
        .frame_busy_o      (frame_busy)
    );

    // --------------------------------------------------
    // per-port datapath, held in clear while not enabled
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        tx_beat_t tx_rd_beat;
        logic     tx_rd_valid;
        logic     tx_rd_ready;
        rx_beat_t cut_beat;
        logic     cut_valid;
        logic     rx_full;

        stream_fifo #(.beat_t(tx_beat_t)) u_tx_fifo (
            .clk125M (clk125M), .rst_n_i (rst_n_i), .clear_i (!port_en[g]),
            .wr_beat_i (tx_wr_beat), .wr_valid_i (tx_wr_valid[g]), .full_o (),
            .rd_beat_o (tx_rd_beat), .rd_valid_o (tx_rd_valid), .rd_ready_i (tx_rd_ready)
        );

        mac_tx_feeder u_feeder (
            .clk125M (clk125M), .rst_n_i (rst_n_i), .enable_i (port_en[g]),
            .fifo_beat_i (tx_rd_beat), .fifo_valid_i (tx_rd_valid),
            .fifo_ready_o (tx_rd_ready),
            .mac_tx_req_o (mac_tx_req_o[g]), .mac_tx_ack_i (mac_tx_ack_i[g]),
            .mac_tx_data_o (mac_tx_data_o[g]), .mac_tx_valid_o (mac_tx_valid_o[g]),
            .mac_tx_sof_o (mac_tx_sof_o[g]), .mac_tx_last_o (mac_tx_last_o[g])
        );

        rx_payload_cut u_cut (
            .clk125M (clk125M), .rst_n_i (rst_n_i),
            .mac_rx_data_i (mac_rx_data_i[g]), .mac_rx_valid_i (mac_rx_valid_i[g]),
            .mac_rx_sof_i (mac_rx_sof_i[g]), .mac_rx_eof_i (mac_rx_eof_i[g]),
            .cut_beat_o (cut_beat), .cut_valid_o (cut_valid)
        );

        // cut beats are lost once the buffer is full
        stream_fifo #(.beat_t(rx_beat_t)) u_rx_fifo (
            .clk125M (clk125M), .rst_n_i (rst_n_i), .clear_i (!port_en[g]),
            .wr_beat_i (cut_beat), .wr_valid_i (cut_valid && !rx_full), .full_o (rx_full),
            .rd_beat_o (rx_beats[g]), .rd_valid_o (rx_valid[g]), .rd_ready_i (rx_ready[g])
        );
    end

endmodule

`default_nettype wire

//--- source/mac_tx_feeder.sv
// mac transmit feeder
// requests the line while a frame waits and streams one frame per grant
`timescale 1ns/1ps
`default_nettype none

module mac_tx_feeder import bridge_pkg::*; (
    input  logic     clk125M,
    input  logic     rst_n_i,
    input  logic     enable_i,
    input  tx_beat_t fifo_beat_i,
    input  logic     fifo_valid_i,
    output logic     fifo_ready_o,
    output logic     mac_tx_req_o,
    input  logic     mac_tx_ack_i,
    output byte_t    mac_tx_data_o,
    output logic     mac_tx_valid_o,
    output logic     mac_tx_sof_o,
    output logic     mac_tx_last_o
);

    typedef enum logic [1:0] {FEED_IDLE, FEED_REQ, FEED_SEND} feed_state_t;

    feed_state_t state;
    logic        ack_q;
    logic        grant;
    logic        pop;

    assign grant        = mac_tx_ack_i && !ack_q;   // fresh ack, old grant released
    assign fifo_ready_o = enable_i && ((state == FEED_REQ && grant) ||
                                       (state == FEED_SEND && mac_tx_ack_i));
    assign pop          = fifo_ready_o && fifo_valid_i;
    assign mac_tx_req_o = (state != FEED_IDLE);

    always_ff @(posedge clk125M) begin
        if (!rst_n_i || !enable_i) begin
            state          <= FEED_IDLE;
            mac_tx_valid_o <= 1'b0;
            mac_tx_sof_o   <= 1'b0;
            mac_tx_last_o  <= 1'b0;
        end else begin
            case (state)
                FEED_IDLE: if (fifo_valid_i) state <= FEED_REQ;
                FEED_REQ:  if (pop) state <= fifo_beat_i.last ? FEED_IDLE : FEED_SEND;
                FEED_SEND: if (pop && fifo_beat_i.last) state <= FEED_IDLE;
                default:   state <= FEED_IDLE;
            endcase
            mac_tx_valid_o <= pop;
            mac_tx_sof_o   <= pop && (state == FEED_REQ);   // first byte of grant
            mac_tx_last_o  <= pop && fifo_beat_i.last;
        end
    end

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= mac_tx_ack_i;
        end
    end

    always_ff @(posedge clk125M) begin
        if (pop) mac_tx_data_o <= fifo_beat_i.data;
    end

    // mac keeps ack up until it has seen last
    a_valid_in_grant: assert property (@(posedge clk125M) disable iff (!rst_n_i)
        mac_tx_valid_o |-> mac_tx_ack_i)
        else $error("mac tx byte outside grant");

endmodule

`default_nettype wire

//--- source/port_ctrl.sv
// port enable control
// picks the working port and moves the selection only between uplink frames
`timescale 1ns/1ps
`default_nettype none

module port_ctrl import bridge_pkg::*; (
    input  logic       clk125M,
    input  logic       rst_n_i,
    input  logic       module_en_i,
    input  port_idx_t  port_sel_i,
    input  port_mask_t link_up_i,
    input  logic       channel_up_i,
    input  logic       frame_busy_i,
    output port_mask_t port_en_o,
    output port_idx_t  active_port_o
);

    port_mask_t sel_mask;
    logic       sel_ok;
    logic       cur_ok;

    assign sel_mask = port_mask_t'(1) << port_sel_i;
    assign sel_ok   = module_en_i && channel_up_i && link_up_i[port_sel_i];
    assign cur_ok   = module_en_i && channel_up_i && link_up_i[active_port_o];

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            port_en_o     <= '0;
            active_port_o <= '0;
        end else if (!frame_busy_i) begin   // frame boundary, take new request
            active_port_o <= port_sel_i;
            port_en_o     <= sel_ok ? sel_mask : '0;
        end else if (!cur_ok) begin
            port_en_o <= '0;    // link or channel lost mid frame
        end
    end

    // at most one port may own the uplink
    a_en_onehot: assert property (@(posedge clk125M) disable iff (!rst_n_i)
        $onehot0(port_en_o))
        else $error("more than one port enabled");

endmodule

`default_nettype wire

//--- source/rx_payload_cut.sv
// receive payload cut
// drops the first RX_HDR_BYTES bytes of every mac frame, one cycle latency
`timescale 1ns/1ps
`default_nettype none

module rx_payload_cut import bridge_pkg::*; (
    input  logic     clk125M,
    input  logic     rst_n_i,
    input  byte_t    mac_rx_data_i,
    input  logic     mac_rx_valid_i,
    input  logic     mac_rx_sof_i,
    input  logic     mac_rx_eof_i,
    output rx_beat_t cut_beat_o,
    output logic     cut_valid_o
);

    logic [CUT_CNT_W-1:0] byte_cnt;
    logic [CUT_CNT_W-1:0] byte_idx;
    logic                 keep;

    // position of the current byte in its frame, saturating past the header
    assign byte_idx = mac_rx_sof_i ? '0 : byte_cnt;
    assign keep     = (byte_idx >= CUT_CNT_W'(RX_HDR_BYTES));

    always_ff @(posedge clk125M) begin
        if (!rst_n_i) begin
            byte_cnt    <= '0;
            cut_valid_o <= 1'b0;
        end else begin
            cut_valid_o <= mac_rx_valid_i && keep;
            if (mac_rx_valid_i && byte_idx <= CUT_CNT_W'(RX_HDR_BYTES)) begin
                byte_cnt <= byte_idx + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // payload, flags follow the byte
    // --------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (mac_rx_valid_i) begin
            cut_beat_o.data <= mac_rx_data_i;
            cut_beat_o.sof  <= (byte_idx == CUT_CNT_W'(RX_HDR_BYTES)); // first kept
            cut_beat_o.last <= mac_rx_eof_i;
        end
    end

endmodule

`default_nettype wire

//--- source/stream_fifo.sv
// synchronous stream FIFO
// circular buffer of FIFO_DEPTH beats, beat type set per instance
`timescale 1ns/1ps
`default_nettype none

module stream_fifo import bridge_pkg::*; #(
    parameter type beat_t = tx_beat_t
) (
    input  logic  clk125M,
    input  logic  rst_n_i,
    input  logic  clear_i,
    input  beat_t wr_beat_i,
    input  logic  wr_valid_i,
    output logic  full_o,
    output beat_t rd_beat_o,
    output logic  rd_valid_o,
    input  logic  rd_ready_i
);

    beat_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    assign full_o     = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign rd_valid_o = (count != '0);
    assign rd_beat_o  = mem[rd_ptr];    // head visible the cycle after the write
    assign wr_en      = wr_valid_i && !full_o;
    assign rd_en      = rd_ready_i && rd_valid_o;

    always_ff @(posedge clk125M) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat_i;
        end
    end

    // --------------------------------------------------
    // pointers and fill level
    // --------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (!rst_n_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FIFO_CNT_W'(wr_en) - FIFO_CNT_W'(rd_en);
        end
    end

    // upstream must never push into a full buffer
    a_no_overflow: assert property (@(posedge clk125M) disable iff (!rst_n_i || clear_i)
        !(wr_valid_i && full_o))
        else $error("write into full fifo");

endmodule

`default_nettype wire

//--- source/uplink_mux.sv
// uplink multiplexer
// steers uplink beats to the enabled port and its rx buffer back to the uplink
`timescale 1ns/1ps
`default_nettype none

module uplink_mux import bridge_pkg::*; (
    input  logic       clk125M,
    input  logic       rst_n_i,
    input  port_mask_t port_en_i,
    input  port_idx_t  active_port_i,
    input  byte_t      uplink_rx_data_i,
    input  logic       uplink_rx_valid_i,
    input  logic       uplink_rx_last_i,
    output tx_beat_t   tx_wr_beat_o,
    output port_mask_t tx_wr_valid_o,
    input  rx_beat_t   rx_beats_i [NUM_PORTS],
    input  port_mask_t rx_valid_i,
    output port_mask_t rx_ready_o,
    output byte_t      uplink_tx_data_o,
    output logic       uplink_tx_valid_o,
    output logic       uplink_tx_sof_o,
    output logic       uplink_tx_last_o,
    input  logic       uplink_tx_ready_i,
    output logic       frame_busy_o
);

    rx_beat_t sel_beat;
    logic     xfer;
    logic     in_frame;

    assign tx_wr_beat_o.data = uplink_rx_data_i;
    assign tx_wr_beat_o.last = uplink_rx_last_i;
    assign tx_wr_valid_o     = uplink_rx_valid_i ? port_en_i : '0;  // dropped if none

    assign sel_beat          = rx_beats_i[active_port_i];
    assign uplink_tx_data_o  = sel_beat.data;
    assign uplink_tx_sof_o   = sel_beat.sof;
    assign uplink_tx_last_o  = sel_beat.last;
    assign uplink_tx_valid_o = rx_valid_i[active_port_i] && port_en_i[active_port_i];
    assign rx_ready_o        = uplink_tx_ready_i ? port_en_i : '0;
    assign xfer              = uplink_tx_valid_o && uplink_tx_ready_i;

    always_ff @(posedge clk125M) begin
        if (!rst_n_i || port_en_i == '0) begin
            in_frame <= 1'b0;
        end else if (xfer) begin
            in_frame <= !sel_beat.last;
        end
    end

    // a beat going out right now counts too
    assign frame_busy_o = in_frame || (xfer && !sel_beat.last);

endmodule

`default_nettype wire

//--- testbench/tb_bridge_top.sv
// bridge testbench
// random frames through both bridge directions, checked against a queue model
`timescale 1ns/1ps
`default_nettype none

module tb_bridge_top import bridge_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 600;

    logic       clk125M;
    logic       rst_n_i;
    logic       module_en_i;
    port_idx_t  port_sel_i;
    port_mask_t link_up_i;
    logic       channel_up_i;
    byte_t      uplink_rx_data_i;
    logic       uplink_rx_valid_i;
    logic       uplink_rx_last_i;
    byte_t      uplink_tx_data_o;
    logic       uplink_tx_valid_o;
    logic       uplink_tx_sof_o;
    logic       uplink_tx_last_o;
    logic       uplink_tx_ready_i;
    port_mask_t mac_tx_req_o;
    port_mask_t mac_tx_ack_i;
    byte_t      mac_tx_data_o [NUM_PORTS];
    port_mask_t mac_tx_valid_o;
    port_mask_t mac_tx_sof_o;
    port_mask_t mac_tx_last_o;
    byte_t      mac_rx_data_i [NUM_PORTS];
    port_mask_t mac_rx_valid_i;
    port_mask_t mac_rx_sof_i;
    port_mask_t mac_rx_eof_i;

    // model state
    rx_beat_t    tx_exp_q [$];     // bytes expected at mac tx
    rx_beat_t    rx_exp_q [$];     // beats expected at uplink tx
    port_mask_t  tx_port_mask;     // ports allowed to request
    port_mask_t  ack_next;
    int          ack_wait [NUM_PORTS];
    logic        rand_ready;
    logic        quiet;            // no uplink valid allowed
    logic        up_in_frame;
    int          err_count;
    int          check_count;
    int          test_errs;
    int unsigned seed;
    int          sel;
    int          cur;

    bridge_top u_bridge_top (.*);

    initial begin
        clk125M = 1'b0;
        forever #4 clk125M = ~clk125M;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // --------------------------------------------------
    // drivers and waits
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk125M);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("tests failed");
        $finish;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic apply_config(input logic en, input int port, input port_mask_t link,
                                input logic chan);
        module_en_i  = en;
        port_sel_i   = port_idx_t'(port);
        link_up_i    = link;
        channel_up_i = chan;
        repeat (3) next_cycle();    // commit takes one cycle with no frame open
    endtask

    task automatic send_uplink_frame(input int len, input logic expect_out);
        rx_beat_t beat;
        for (int i = 0; i < len; i++) begin
            beat.data         = byte_t'($urandom);
            beat.sof          = (i == 0);
            beat.last         = (i == len - 1);
            uplink_rx_data_i  = beat.data;
            uplink_rx_valid_i = 1'b1;
            uplink_rx_last_i  = beat.last;
            if (expect_out) tx_exp_q.push_back(beat);
            next_cycle();
        end
        uplink_rx_valid_i = 1'b0;
        uplink_rx_last_i  = 1'b0;
    endtask

    task automatic send_mac_frame(input int port, input int len, input logic expect_out);
        rx_beat_t beat;
        for (int i = 0; i < len; i++) begin
            beat.data            = byte_t'($urandom);
            beat.sof             = (i == RX_HDR_BYTES);  // first byte past the header
            beat.last            = (i == len - 1);
            mac_rx_data_i[port]  = beat.data;
            mac_rx_valid_i[port] = 1'b1;
            mac_rx_sof_i[port]   = (i == 0);
            mac_rx_eof_i[port]   = beat.last;
            if (expect_out && i >= RX_HDR_BYTES) rx_exp_q.push_back(beat);
            next_cycle();
        end
        mac_rx_valid_i[port] = 1'b0;
        mac_rx_sof_i[port]   = 1'b0;
        mac_rx_eof_i[port]   = 1'b0;
    endtask

    task automatic send_blocked(input int port);
        send_uplink_frame(8, 1'b0);
        send_mac_frame(port, 30, 1'b0);
        repeat (10) next_cycle();
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (tx_exp_q.size() != 0 || rx_exp_q.size() != 0) begin
            if (n == TIMEOUT_CYCLES) abort_run(what);
            n++;
            next_cycle();
        end
        repeat (4) next_cycle();    // room for a stray beat to show
    endtask

    task automatic switch_mid_frame(input int port);
        int n;
        n = 0;
        while (!up_in_frame) begin
            if (n == TIMEOUT_CYCLES) abort_run("an uplink frame to start");
            n++;
            next_cycle();
        end
        port_sel_i = port_idx_t'(port);
    endtask

    // --------------------------------------------------
    // mac tx model and uplink sink
    // --------------------------------------------------
    always @(negedge clk125M) begin : mac_ack_model
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n_i) begin
                ack_next[p] = 1'b0;
                ack_wait[p] = 0;
            end else if (mac_tx_ack_i[p]) begin
                ack_next[p] = !(mac_tx_valid_o[p] && mac_tx_last_o[p]);  // hold until last
            end else if (mac_tx_req_o[p]) begin
                if (ack_wait[p] == 0) begin
                    ack_next[p] = 1'b1;
                    ack_wait[p] = $urandom % 5;
                end else begin
                    ack_wait[p]--;
                end
            end
        end
    end

    always @(posedge clk125M) begin
        #1;
        mac_tx_ack_i      = ack_next;
        uplink_tx_ready_i = rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    always @(negedge clk125M) begin : monitor
        rx_beat_t exp;
        if (rst_n_i) begin
            if ((mac_tx_req_o & ~tx_port_mask) != '0) begin
                check_mask("mac_tx_req_o", mac_tx_req_o & ~tx_port_mask, '0);
            end
            if (quiet && uplink_tx_valid_o) begin
                check_flag("uplink_tx_valid_o", uplink_tx_valid_o, 1'b0);
            end
            if (mac_tx_valid_o != '0) begin
                check_mask("mac_tx_valid_o", mac_tx_valid_o, tx_port_mask);
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (mac_tx_valid_o[p] && tx_exp_q.size() == 0) begin
                        err_count++;
                        $display("port %0d sent a mac tx byte nobody expected", p);
                    end else if (mac_tx_valid_o[p]) begin
                        exp = tx_exp_q.pop_front();
                        check_byte("mac_tx_data_o", mac_tx_data_o[p], exp.data);
                        check_flag("mac_tx_sof_o", mac_tx_sof_o[p], exp.sof);
                        check_flag("mac_tx_last_o", mac_tx_last_o[p], exp.last);
                    end
                end
            end
            if (uplink_tx_valid_o && uplink_tx_ready_i) begin
                if (rx_exp_q.size() == 0) begin
                    err_count++;
                    $display("uplink sent a beat nobody expected at %0t", $time);
                end else begin
                    exp = rx_exp_q.pop_front();
                    check_byte("uplink_tx_data_o", uplink_tx_data_o, exp.data);
                    check_flag("uplink_tx_sof_o", uplink_tx_sof_o, exp.sof);
                    check_flag("uplink_tx_last_o", uplink_tx_last_o, exp.last);
                end
                up_in_frame = !uplink_tx_last_o;
            end
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin : main
        seed = 32'hba1;
        void'($urandom(seed));
        rst_n_i           = 1'b0;
        module_en_i       = 1'b0;
        port_sel_i        = '0;
        link_up_i         = '0;
        channel_up_i      = 1'b0;
        uplink_rx_data_i  = '0;
        uplink_rx_valid_i = 1'b0;
        uplink_rx_last_i  = 1'b0;
        uplink_tx_ready_i = 1'b1;
        mac_tx_ack_i      = '0;
        mac_rx_valid_i    = '0;
        mac_rx_sof_i      = '0;
        mac_rx_eof_i      = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            mac_rx_data_i[p] = '0;
            ack_wait[p]      = 0;
        end
        tx_port_mask = '0;
        ack_next     = '0;
        rand_ready   = 1'b0;
        quiet        = 1'b0;
        up_in_frame  = 1'b0;
        err_count    = 0;
        check_count  = 0;
        test_errs    = 0;
        repeat (4) @(posedge clk125M);
        #1;
        rst_n_i = 1'b1;

        @(negedge clk125M);
        check_mask("mac_tx_req_o", mac_tx_req_o, '0);
        check_mask("mac_tx_valid_o", mac_tx_valid_o, '0);
        check_flag("uplink_tx_valid_o", uplink_tx_valid_o, 1'b0);
        report_test(1, "after reset");
        next_cycle();

        sel = $urandom % NUM_PORTS;
        apply_config(1'b1, sel, '1, 1'b1);
        tx_port_mask = port_mask_t'(1) << sel;
        for (int f = 0; f < 8; f++) begin
            send_uplink_frame(1 + $urandom % 24, 1'b1);
            wait_drained("a mac tx frame");
        end
        tx_port_mask = '0;
        report_test(2, "uplink to mac");

        sel = $urandom % NUM_PORTS;
        apply_config(1'b1, sel, '1, 1'b1);
        send_mac_frame(sel, RX_HDR_BYTES, 1'b1);         // header only, nothing out
        wait_drained("an uplink frame");
        send_mac_frame(sel, RX_HDR_BYTES + 1, 1'b1);
        wait_drained("an uplink frame");
        for (int f = 0; f < 10; f++) begin
            send_mac_frame(sel, 1 + $urandom % 40, 1'b1);
            wait_drained("an uplink frame");
        end
        report_test(3, "mac rx to uplink");

        rand_ready = 1'b1;
        for (int f = 0; f < 12; f++) begin
            send_mac_frame(sel, RX_HDR_BYTES + 1 + $urandom % 28, 1'b1);
            wait_drained("an uplink frame under back-pressure");
        end
        report_test(4, "back-pressure");

        quiet = 1'b1;
        apply_config(1'b0, sel, '1, 1'b1);
        send_blocked(sel);
        apply_config(1'b1, sel, ~(port_mask_t'(1) << sel), 1'b1);
        send_blocked(sel);
        apply_config(1'b1, sel, '1, 1'b0);
        send_blocked(sel);
        apply_config(1'b1, sel, '1, 1'b1);
        send_mac_frame((sel + 1) % NUM_PORTS, 30, 1'b0);  // unselected port
        repeat (10) next_cycle();
        quiet = 1'b0;
        report_test(5, "port gating");

        apply_config(1'b1, NUM_PORTS - 1, '1, 1'b1);
        cur = NUM_PORTS - 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            fork
                send_mac_frame(cur, RX_HDR_BYTES + 16 + $urandom % 8, 1'b1);
                switch_mid_frame(p);
            join
            wait_drained("a frame across a port switch");
            cur = p;
        end
        send_mac_frame(cur, RX_HDR_BYTES + 10, 1'b1);
        wait_drained("a frame on the last port");
        report_test(6, "port switching");

        $display("tests run: 6, checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
